// File: hw/vid_settings.svh
// Raster sizes and sync positions
// Tile map geometry and fetch length
// Graphics memory map and CPU register addresses
`ifndef VID_SETTINGS_SVH
`define VID_SETTINGS_SVH

// Raster, in clk cycles and lines
`define VID_H_ACTIVE    32
`define VID_H_TOTAL     64
`define VID_V_ACTIVE    24
`define VID_V_TOTAL     32
`define VID_HS_START    40
`define VID_HS_END      48
`define VID_VS_START    26
`define VID_VS_END      28

// 32x32 map of 8x8 tiles, 4 bpp
`define VID_MAP_COLS    32
`define VID_FETCH_TILES 5
`define VID_PAT_BASE    16'h1000

// CPU register map
`define VID_REG_HSCR    8'h00
`define VID_REG_VSCR    8'h01
`define VID_REG_BACK    8'h02
`define VID_PAL_BASE    8'h80
`endif

// File: hw/vid_raster_pkg.sv
// Raster position and blanking type
// Line fetch command from the timer
// Graphics memory request and response types
package vid_raster_pkg;

    // Screen position plus blanking and sync, active low blanks
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } raster_t;

    // One-cycle start with the line about to be shown
    typedef struct packed {
        logic       start;
        logic [8:0] line;
    } fetch_cmd_t;

    // Request side, ready travels on its own wire
    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
    } gfx_req_t;

    // Eight 4-bit pixels, leftmost in the low nibble
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } gfx_rsp_t;

endpackage

// File: hw/vid_cpu_pkg.sv
// CPU side types
// 5:5:5 colour, CPU data word with its two decodings
// Single-cycle write strobe
package vid_cpu_pkg;

    // Colour word, top bit unused
    typedef struct packed {
        logic       spare;
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } color_t;

    // Scroll registers only keep the low byte
    typedef struct packed {
        logic [7:0] unused;
        logic [7:0] value;
    } scroll_t;

    // Same 16 bits seen as raw, colour or scroll
    typedef union packed {
        logic [15:0] raw;
        color_t      color;
        scroll_t     scr;
    } cpu_word_u;

    // Write strobe, always accepted
    typedef struct packed {
        logic       wr;
        logic [7:0] addr;
        cpu_word_u  data;
    } cpu_wr_t;

endpackage

// File: hw/vid_timer.sv
// Video timer
// Horizontal and vertical counters, blanking and sync
// Line fetch command for each visible line
`timescale 1ns/100ps
`include "vid_settings.svh"

module vid_timer (
    input  logic                       clk,
    input  logic                       arst_n,
    output vid_raster_pkg::raster_t    raster,
    output vid_raster_pkg::fetch_cmd_t fetch
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic [8:0] next_line;
    logic       h_last;

    assign h_last    = hcnt == 9'(`VID_H_TOTAL - 1);
    assign next_line = (vcnt == 9'(`VID_V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            if (h_last) begin
                hcnt <= '0;
                vcnt <= next_line;
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    // Blanking and sync straight from the counters
    always_comb begin
        raster.hdump = hcnt;
        raster.vdump = vcnt;
        raster.lhbl  = hcnt < 9'(`VID_H_ACTIVE);
        raster.lvbl  = vcnt < 9'(`VID_V_ACTIVE);
        raster.hs    = hcnt >= 9'(`VID_HS_START) && hcnt < 9'(`VID_HS_END);
        raster.vs    = vcnt >= 9'(`VID_VS_START) && vcnt < 9'(`VID_VS_END);
    end

    // Fetch starts as horizontal blanking begins.
    // The last blanking line wraps so line 0 also gets fetched
    always_comb begin
        fetch.start = hcnt == 9'(`VID_H_ACTIVE) && next_line < 9'(`VID_V_ACTIVE);
        fetch.line  = next_line;
    end

endmodule

// File: hw/vid_mmr.sv
// CPU register block
// Horizontal and vertical scroll, background colour
// Palette range forwarded as a filtered write strobe
`timescale 1ns/100ps
`include "vid_settings.svh"

module vid_mmr (
    input  logic                  clk,
    input  logic                  arst_n,
    input  vid_cpu_pkg::cpu_wr_t  cpu_wr,
    output logic [7:0]            hscr,
    output logic [7:0]            vscr,
    output vid_cpu_pkg::color_t   back_color,
    output vid_cpu_pkg::cpu_wr_t  pal_wr
);

    logic in_pal;

    assign in_pal = cpu_wr.addr >= `VID_PAL_BASE;

    // Register writes land on the next clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hscr       <= '0;
            vscr       <= '0;
            back_color <= '0;
        end else if (cpu_wr.wr) begin
            case (cpu_wr.addr)
                `VID_REG_HSCR: begin
                    hscr <= cpu_wr.data.scr.value;
                end
                `VID_REG_VSCR: begin
                    vscr <= cpu_wr.data.scr.value;
                end
                `VID_REG_BACK: begin
                    back_color <= cpu_wr.data.color;
                end
                default: begin
                end
            endcase
        end
    end

    // Palette RAM lives in the mixer
    always_comb begin
        pal_wr    = cpu_wr;
        pal_wr.wr = cpu_wr.wr && in_pal;
    end

endmodule

// File: hw/vid_tile.sv
// Scrolling tile layer
// Per-line map and pattern fetch over valid/ready
// Line buffer with bank and colour index per pixel
// Fine scroll applied on readout
`timescale 1ns/100ps
`include "vid_settings.svh"

module vid_tile (
    input  logic                       clk,
    input  logic                       arst_n,
    input  vid_raster_pkg::raster_t    raster,
    input  vid_raster_pkg::fetch_cmd_t fetch,
    input  logic [7:0]                 hscr,
    input  logic [7:0]                 vscr,
    input  logic                       gfx_ready,
    input  vid_raster_pkg::gfx_rsp_t   gfx_rsp,
    output vid_raster_pkg::gfx_req_t   gfx_req,
    output logic [6:0]                 pxl
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MAP,
        ST_MAP_WAIT,
        ST_PAT,
        ST_PAT_WAIT,
        ST_DONE
    } state_t;

    state_t     state;
    logic [7:0] hscr_l;
    logic [7:0] src_row;
    logic [2:0] col;
    logic [4:0] map_col;
    logic [8:0] tile_idx;
    logic [2:0] tile_bank;
    logic       tile_flip;
    logic [5:0] wr_base;
    logic [5:0] rd_idx;
    logic       active;
    logic       abandon;
    logic [6:0] line_buf [0:`VID_FETCH_TILES*8-1];

    assign active  = raster.lhbl && raster.lvbl;
    // Display has started, whatever is left of the fetch is dropped
    assign abandon = active && state != ST_IDLE;

    assign map_col = hscr_l[7:3] + 5'(col);
    assign wr_base = {col, 3'b000};
    assign rd_idx  = raster.hdump[5:0] + 6'(hscr_l[2:0]);

    // Address is stable for as long as the state is
    always_comb begin
        gfx_req.valid = state == ST_MAP || state == ST_PAT;
        if (state == ST_PAT || state == ST_PAT_WAIT) begin
            gfx_req.addr = `VID_PAT_BASE + {4'd0, tile_idx, src_row[2:0]};
        end else begin
            gfx_req.addr = 16'(src_row[7:3]) * 16'(`VID_MAP_COLS) + 16'(map_col);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            col     <= '0;
            hscr_l  <= '0;
            src_row <= '0;
        end else if (abandon) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fetch.start) begin
                        hscr_l  <= hscr;
                        src_row <= fetch.line[7:0] + vscr;
                        col     <= '0;
                        state   <= ST_MAP;
                    end
                end
                ST_MAP: if (gfx_ready) state <= ST_MAP_WAIT;
                ST_MAP_WAIT: if (gfx_rsp.valid) state <= ST_PAT;
                ST_PAT: if (gfx_ready) state <= ST_PAT_WAIT;
                ST_PAT_WAIT: begin
                    if (gfx_rsp.valid) begin
                        if (col == 3'(`VID_FETCH_TILES - 1)) begin
                            state <= ST_DONE;
                        end else begin
                            col   <= col + 3'd1;
                            state <= ST_MAP;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Map word, then eight pixels per pattern row
    always_ff @(posedge clk) begin
        if (state == ST_MAP_WAIT && gfx_rsp.valid) begin
            tile_idx  <= gfx_rsp.data[8:0];
            tile_bank <= gfx_rsp.data[11:9];
            tile_flip <= gfx_rsp.data[12];
        end
        if (state == ST_PAT_WAIT && gfx_rsp.valid) begin
            for (int i = 0; i < 8; i++) begin
                line_buf[wr_base + 6'(i)] <= {tile_bank, tile_flip ?
                    gfx_rsp.data[(7 - i) * 4 +: 4] : gfx_rsp.data[i * 4 +: 4]};
            end
        end
        pxl <= active ? line_buf[rd_idx] : '0;
    end

endmodule

// File: hw/vid_colmix.sv
// Colour mixer
// 128-entry palette RAM written by the CPU
// Index 0 of every bank shows the background colour
// Output register with sync and enable aligned to the colour
`timescale 1ns/100ps
`include "vid_settings.svh"

module vid_colmix (
    input  logic                    clk,
    input  logic                    arst_n,
    input  vid_raster_pkg::raster_t raster,
    input  logic [6:0]              pxl,
    input  vid_cpu_pkg::cpu_wr_t    pal_wr,
    input  vid_cpu_pkg::color_t     back_color,
    output logic [4:0]              red,
    output logic [4:0]              green,
    output logic [4:0]              blue,
    output logic                    de,
    output logic                    hs,
    output logic                    vs
);

    vid_cpu_pkg::color_t pal_ram [0:127];
    vid_cpu_pkg::color_t pal_color;
    vid_cpu_pkg::color_t mix_color;
    logic [6:0]          pal_idx;
    logic                act_d;
    logic                hs_d;
    logic                vs_d;

    assign pal_idx = 7'(pal_wr.addr - `VID_PAL_BASE);

    always_ff @(posedge clk) begin
        if (pal_wr.wr) begin
            pal_ram[pal_idx] <= pal_wr.data.color;
        end
    end

    // pxl is {bank, index}, so bank picks a group of 16
    assign pal_color = pal_ram[pxl];
    assign mix_color = (pxl[3:0] == 4'd0) ? back_color : pal_color;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_d <= 1'b0;
            hs_d  <= 1'b0;
            vs_d  <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
            de    <= 1'b0;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else begin
            // First stage matches the tile layer pixel delay
            act_d <= raster.lhbl && raster.lvbl;
            hs_d  <= raster.hs;
            vs_d  <= raster.vs;
            red   <= act_d ? mix_color.r : 5'd0;
            green <= act_d ? mix_color.g : 5'd0;
            blue  <= act_d ? mix_color.b : 5'd0;
            de    <= act_d;
            hs    <= hs_d;
            vs    <= vs_d;
        end
    end

endmodule

// File: hw/vid_top.sv
// Tile video top level
// Timer, CPU registers, tile layer and colour mixer
`timescale 1ns/100ps

module vid_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  vid_cpu_pkg::cpu_wr_t     cpu_wr,
    input  logic                     gfx_ready,
    input  vid_raster_pkg::gfx_rsp_t gfx_rsp,
    output vid_raster_pkg::gfx_req_t gfx_req,
    output logic [4:0]               red,
    output logic [4:0]               green,
    output logic [4:0]               blue,
    output logic                     de,
    output logic                     hs,
    output logic                     vs
);

    vid_raster_pkg::raster_t    raster;
    vid_raster_pkg::fetch_cmd_t fetch;
    vid_cpu_pkg::cpu_wr_t       pal_wr;
    vid_cpu_pkg::color_t        back_color;
    logic [7:0]                 hscr;
    logic [7:0]                 vscr;
    logic [6:0]                 pxl;

    vid_timer u_timer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .raster     ( raster     ),
        .fetch      ( fetch      )
    );

    vid_mmr u_mmr (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cpu_wr     ( cpu_wr     ),
        .hscr       ( hscr       ),
        .vscr       ( vscr       ),
        .back_color ( back_color ),
        .pal_wr     ( pal_wr     )
    );

    vid_tile u_tile (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .raster     ( raster     ),
        .fetch      ( fetch      ),
        .hscr       ( hscr       ),
        .vscr       ( vscr       ),
        .gfx_ready  ( gfx_ready  ),
        .gfx_rsp    ( gfx_rsp    ),
        .gfx_req    ( gfx_req    ),
        .pxl        ( pxl        )
    );

    vid_colmix u_colmix (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .raster     ( raster     ),
        .pxl        ( pxl        ),
        .pal_wr     ( pal_wr     ),
        .back_color ( back_color ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .de         ( de         ),
        .hs         ( hs         ),
        .vs         ( vs         )
    );

endmodule

// File: verif/vid_sva.sv
// Bound assertions for the video top level
// Graphics request handshake, blanking against sync, reset values
`timescale 1ns/100ps

module vid_sva (
    input logic                     clk,
    input logic                     arst_n,
    input vid_raster_pkg::gfx_req_t gfx_req,
    input logic                     gfx_ready,
    input vid_raster_pkg::gfx_rsp_t gfx_rsp,
    input logic                     de,
    input logic                     hs,
    input logic                     vs
);

    logic outstanding;

    // Set by a transfer, cleared by its response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 1'b0;
        end else if (gfx_req.valid && gfx_ready) begin
            outstanding <= 1'b1;
        end else if (gfx_rsp.valid) begin
            outstanding <= 1'b0;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        gfx_req.valid && !gfx_ready |=> gfx_req.valid && $stable(gfx_req.addr))
        else $error("gfx request dropped or changed before ready");

    a_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        outstanding |-> !gfx_req.valid)
        else $error("second gfx request before the response");

    a_de_sync: assert property (@(posedge clk) disable iff (!arst_n)
        de |-> !hs && !vs)
        else $error("de high during sync");

    a_reset: assert property (@(posedge clk)
        !arst_n |-> !de && !hs && !vs && !gfx_req.valid)
        else $error("outputs not idle in reset");

endmodule

bind vid_top vid_sva i_sva (
    .clk       ( clk       ),
    .arst_n    ( arst_n    ),
    .gfx_req   ( gfx_req   ),
    .gfx_ready ( gfx_ready ),
    .gfx_rsp   ( gfx_rsp   ),
    .de        ( de        ),
    .hs        ( hs        ),
    .vs        ( vs        )
);

// File: verif/vid_tb.sv
// Testbench for the tile video top level
// Clock, reset, CPU register and palette writes
// Graphics memory model with random ready stalls
// Reference colour function and per-pixel compare process
`timescale 1ns/100ps
`include "vid_settings.svh"

module vid_tb;

    localparam int WAIT_LIMIT = 5000;
    localparam int NUM_STEPS  = 8;

    logic                     clk;
    logic                     arst_n;
    vid_cpu_pkg::cpu_wr_t     cpu_wr;
    logic                     gfx_ready;
    vid_raster_pkg::gfx_rsp_t gfx_rsp;
    vid_raster_pkg::gfx_req_t gfx_req;
    logic [4:0]               red;
    logic [4:0]               green;
    logic [4:0]               blue;
    logic                     de;
    logic                     hs;
    logic                     vs;

    // Graphics memory and a copy of the CPU visible state
    logic [31:0]         map_mem [0:1023];
    logic [31:0]         pat_mem [0:4095];
    vid_cpu_pkg::color_t pal_m [0:127];
    vid_cpu_pkg::color_t back_m;
    logic [7:0]          hscr_m;
    logic [7:0]          vscr_m;

    logic [31:0] rng;
    logic        pending;
    logic [15:0] pend_addr;
    logic        stall_en;
    int          since_stall;
    logic        check_on;
    int          frames_done;
    int          value_errors;
    int          timeouts;

    vid_top i_dut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cpu_wr    ( cpu_wr    ),
        .gfx_ready ( gfx_ready ),
        .gfx_rsp   ( gfx_rsp   ),
        .gfx_req   ( gfx_req   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .de        ( de        ),
        .hs        ( hs        ),
        .vs        ( vs        )
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] mem_read(input logic [15:0] addr);
        if (addr < `VID_PAT_BASE) begin
            return map_mem[addr[9:0]];
        end
        return pat_mem[12'(addr - `VID_PAT_BASE)];
    endfunction

    // Expected colour of screen pixel (x, y) from scroll, map, pattern and palette
    function automatic logic [14:0] ref_color(input int x, input int y);
        logic [7:0]  row;
        logic [7:0]  sx;
        logic [31:0] mword;
        logic [31:0] pat;
        logic [2:0]  px;
        logic [3:0]  nib;
        row   = 8'(y) + vscr_m;
        sx    = 8'(x) + hscr_m;
        mword = map_mem[{row[7:3], sx[7:3]}];
        pat   = pat_mem[{mword[8:0], row[2:0]}];
        px    = mword[12] ? 3'd7 - sx[2:0] : sx[2:0];
        nib   = pat[px * 4 +: 4];
        if (nib == 4'd0) begin
            return {back_m.r, back_m.g, back_m.b};
        end
        return {pal_m[{mword[11:9], nib}].r, pal_m[{mword[11:9], nib}].g,
                pal_m[{mword[11:9], nib}].b};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_vs(input logic level, input string what);
        int n;
        n = 0;
        while (vs !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (vs !== level) begin
            $display("Timeout: vs did not go %0d while waiting for %s", level, what);
            timeouts++;
        end
    endtask

    task automatic cpu_write(input logic [7:0] addr, input logic [15:0] data);
        cpu_wr.wr       = 1'b1;
        cpu_wr.addr     = addr;
        cpu_wr.data.raw = data;
        if (addr == `VID_REG_HSCR) hscr_m = data[7:0];
        if (addr == `VID_REG_VSCR) vscr_m = data[7:0];
        if (addr == `VID_REG_BACK) back_m = data;
        if (addr >= `VID_PAL_BASE) pal_m[7'(addr - `VID_PAL_BASE)] = data;
        @(negedge clk);
        cpu_wr.wr = 1'b0;
    endtask

    // Memory answers one cycle after each transfer
    always @(negedge clk) begin
        logic [31:0] r;
        gfx_rsp.valid = 1'b0;
        gfx_rsp.data  = '0;
        if (pending) begin
            gfx_rsp.valid = 1'b1;
            gfx_rsp.data  = mem_read(pend_addr);
            pending       = 1'b0;
        end
        gfx_ready = 1'b1;
        since_stall++;
        if (stall_en && since_stall >= 4) begin
            r = next_rand();
            if (r[1:0] == 2'd0) begin
                gfx_ready   = 1'b0;
                since_stall = 0;
            end
        end
        if (arst_n && gfx_req.valid && gfx_ready) begin
            pending   = 1'b1;
            pend_addr = gfx_req.addr;
        end
    end

    // One frame of de pixels counted from the end of vs
    task automatic check_frame();
        int n;
        int px;
        int extra;
        for (int y = 0; y < `VID_V_ACTIVE; y++) begin
            n = 0;
            while (!de && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!de) begin
                $display("Timeout: de did not rise for line %0d", y);
                timeouts++;
                return;
            end
            px = 0;
            while (de && px < WAIT_LIMIT) begin
                check_value($sformatf("colour at (%0d,%0d)", px, y),
                            32'({red, green, blue}), 32'(ref_color(px, y)));
                px++;
                @(negedge clk);
            end
            if (de) begin
                $display("Timeout: de did not fall on line %0d", y);
                timeouts++;
                return;
            end
            check_value($sformatf("de pixels on line %0d", y), px, `VID_H_ACTIVE);
            // hs follows the end of de after the front porch
            n = 0;
            while (!hs && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!hs) begin
                $display("Timeout: hs did not rise on line %0d", y);
                timeouts++;
                return;
            end
            check_value($sformatf("hs delay on line %0d", y), n,
                        `VID_HS_START - `VID_H_ACTIVE);
            n = 0;
            while (hs && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (hs) begin
                $display("Timeout: hs did not fall on line %0d", y);
                timeouts++;
                return;
            end
            check_value($sformatf("hs width on line %0d", y), n,
                        `VID_HS_END - `VID_HS_START);
        end
        n     = 0;
        extra = 0;
        while (!vs && n < WAIT_LIMIT) begin
            if (de) extra++;
            @(negedge clk);
            n++;
        end
        if (!vs) begin
            $display("Timeout: vs did not rise after the last checked line");
            timeouts++;
        end
        check_value("de cycles after line 23", extra, 0);
    endtask

    initial begin
        forever begin
            wait_vs(1'b1, "frame start in compare");
            wait_vs(1'b0, "end of vs in compare");
            if (check_on) begin
                check_frame();
                frames_done++;
            end
        end
    end

    initial begin
        logic [7:0] h_list [0:NUM_STEPS-1];
        logic [7:0] v_list [0:NUM_STEPS-1];
        logic [31:0] r;
        int n;
        h_list = '{8'd3, 8'd8, 8'd250, 8'd0, 8'd0, 8'd250, 8'd3, 8'd100};
        v_list = '{8'd0, 8'd0, 8'd0, 8'd5, 8'd230, 8'd250, 8'd17, 8'd77};
        clk = 1'b0;
        arst_n = 1'b0;
        cpu_wr = '0;
        gfx_ready = 1'b1;
        gfx_rsp = '0;
        rng = 32'd31;
        pending = 1'b0;
        pend_addr = '0;
        stall_en = 1'b0;
        since_stall = 0;
        check_on = 1'b0;
        frames_done = 0;
        value_errors = 0;
        timeouts = 0;
        hscr_m = '0;
        vscr_m = '0;
        back_m = '0;
        for (int i = 0; i < 1024; i++) begin
            r = next_rand();
            map_mem[i] = {19'd0, r[12:0]};
        end
        for (int i = 0; i < 4096; i++) begin
            pat_mem[i] = next_rand();
        end
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // Palette is loaded over two vs windows
        wait_vs(1'b1, "first vs window");
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            cpu_write(8'(`VID_PAL_BASE + i), {1'b0, r[14:0]});
        end
        wait_vs(1'b0, "end of first vs window");
        wait_vs(1'b1, "second vs window");
        for (int i = 64; i < 128; i++) begin
            r = next_rand();
            cpu_write(8'(`VID_PAL_BASE + i), {1'b0, r[14:0]});
        end
        cpu_write(`VID_REG_BACK, 16'h1234);
        cpu_write(`VID_REG_HSCR, 16'h0000);
        cpu_write(`VID_REG_VSCR, 16'h0000);
        check_on = 1'b1;

        for (int s = 0; s < NUM_STEPS; s++) begin
            wait_vs(1'b0, "end of vs before a register step");
            wait_vs(1'b1, "vs window for a register step");
            cpu_write(`VID_REG_HSCR, {8'd0, h_list[s]});
            cpu_write(`VID_REG_VSCR, {8'd0, v_list[s]});
            if (s == 5) begin
                cpu_write(`VID_REG_BACK, 16'h7c1f);
                cpu_write(8'h85, 16'h03e0);
            end
            if (s == 6) stall_en = 1'b1;
        end

        n = 0;
        while (frames_done < NUM_STEPS + 1 && n < 4 * WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (frames_done < NUM_STEPS + 1) begin
            $display("Timeout: only %0d frames were checked", frames_done);
            timeouts++;
        end
        $display("Checked %0d frames, %0d value errors, %0d timeouts",
                 frames_done, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/vid_raster_pkg.sv
hw/vid_cpu_pkg.sv
hw/vid_timer.sv
hw/vid_mmr.sv
hw/vid_tile.sv
hw/vid_colmix.sv
hw/vid_top.sv
verif/vid_sva.sv
verif/vid_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run, pass is found by searching the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module vid_tb -o vid_sim &&
./obj_dir/vid_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
